// ==== soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

//////////////////////////////////////////////////
// Clocking
//////////////////////////////////////////////////

// System clock in Hz, returned by the frequency register
`define SYS_CLK_HZ 32'd25_000_000

// Cycles per UART bit, kept small for short simulations
`define CLKS_PER_BIT 8

//////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////

// Block RAM starts at address zero
`define BRAM_WORDS 256

`define UART_TX_ADDR  32'h1000_0000
`define UART_RX_ADDR  32'h1000_0004
`define UART_LSR_ADDR 32'h1000_0008
`define FREQ_ADDR     32'h1000_000C

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

  // Target picked by the decode stage for one host request
  typedef enum logic [2:0] {
    tgt_none,
    tgt_bram,
    tgt_uart_tx,
    tgt_uart_rx,
    tgt_uart_lsr,
    tgt_freq,
    tgt_unmapped
  } target_e;

  // 16550-style line status, laid over a full bus word
  typedef struct packed {
    logic [16:0] rsvd_hi;   // 31:15
    logic        tx_idle;   // 14, shifter and holding both empty
    logic        thr_empty; // 13
    logic [3:0]  rsvd_mid;  // 12:9
    logic        rx_ready;  // 8
    logic [7:0]  rsvd_lo;   // 7:0
  } lsr_t;

  // Response word, seen as plain data or as line status
  typedef union packed {
    logic [31:0] raw;
    lsr_t        lsr;
  } bus_word_u;

endpackage

// ==== bus_if.sv ====
`timescale 1ns/1ps

// Request from the decode stage, broadcast to every target
interface req_if import soc_pkg::*; ();

  target_e     sel;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        strobe;

  modport src (output sel, addr, wdata, wstrb, strobe);
  modport dst (input sel, addr, wdata, wstrb, strobe);

endinterface

// Answer of one target towards the response stage
interface resp_if import soc_pkg::*; ();

  logic      done;
  bus_word_u rdata;

  modport src (output done, rdata);
  modport dst (input done, rdata);

endinterface

// ==== addr_decode.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module addr_decode import soc_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic        mem_valid,
  input  logic [31:0] mem_addr,
  input  logic [3:0]  mem_wstrb,
  input  logic [31:0] mem_wdata,
  input  logic        mem_ready,
  req_if.src          req
);

  logic    busy;
  logic    wr;
  target_e hit;

  assign wr = |mem_wstrb;

  //////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////

  always_comb begin
    if (mem_addr < (`BRAM_WORDS * 4)) begin
      hit = tgt_bram;
    end else begin
      case (mem_addr)
        // TX data is write-only, the other registers are read-only
        `UART_TX_ADDR:  hit = wr ? tgt_uart_tx : tgt_unmapped;
        `UART_RX_ADDR:  hit = wr ? tgt_unmapped : tgt_uart_rx;
        `UART_LSR_ADDR: hit = wr ? tgt_unmapped : tgt_uart_lsr;
        `FREQ_ADDR:     hit = wr ? tgt_unmapped : tgt_freq;
        default:        hit = tgt_unmapped;
      endcase
    end
  end

  // One strobe per request, busy until the host sees ready
  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy       <= 1'b0;
      req.strobe <= 1'b0;
      req.sel    <= tgt_none;
    end else begin
      req.strobe <= 1'b0;
      if (mem_valid && !busy) begin
        busy       <= 1'b1;
        req.strobe <= 1'b1;
        req.sel    <= hit;
      end else if (mem_ready) begin
        busy <= 1'b0;
      end
    end
  end

  // Payload stays put until the next accepted request
  always_ff @(posedge clk) begin
    if (mem_valid && !busy) begin
      req.addr  <= mem_addr;
      req.wdata <= mem_wdata;
      req.wstrb <= mem_wstrb;
    end
  end

  // Ready only ever answers a request that was taken
  a_ready_while_busy: assert property (
    @(posedge clk) disable iff (!resetn)
    mem_ready |-> busy
  );

endmodule

// ==== bram_store.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module bram_store import soc_pkg::*; (
  input  logic clk,
  input  logic resetn,
  req_if.dst   req,
  resp_if.src  resp
);

  localparam int aw = $clog2(`BRAM_WORDS);

  logic [31:0]   mem [`BRAM_WORDS];
  logic [aw-1:0] idx;
  logic          hit;

  // Word index, byte offset bits dropped
  assign idx = req.addr[aw+1:2];
  assign hit = req.strobe && (req.sel == tgt_bram);

  // Read-before-write, old word goes back on a write too
  always_ff @(posedge clk) begin
    if (hit) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
      end
      resp.rdata.raw <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      resp.done <= 1'b0;
    end else begin
      resp.done <= hit;
    end
  end

  // Upper address bits are dropped by the index, so no alias may reach here
  a_addr_in_range: assert property (
    @(posedge clk) disable iff (!resetn)
    hit |-> (req.addr < (`BRAM_WORDS * 4))
  );

endmodule

// ==== uart_tx_port.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module uart_tx_port import soc_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic rx_full,
  req_if.dst   req,
  resp_if.src  tx_resp,
  resp_if.src  lsr_resp,
  output logic uart_tx,
  output logic tx_idle
);

  localparam int bw = $clog2(`CLKS_PER_BIT);

  logic          tx_hit;
  logic          lsr_hit;
  logic          pending;
  logic          load;
  logic          shifting;
  logic          thr_empty;
  logic [9:0]    shift_q;
  logic [bw-1:0] baud_cnt;
  logic [3:0]    bit_cnt;
  lsr_t          lsr_now;

  assign tx_hit  = req.strobe && (req.sel == tgt_uart_tx);
  assign lsr_hit = req.strobe && (req.sel == tgt_uart_lsr);

  // A write waits in pending while a frame is still going out
  assign load    = (tx_hit || pending) && !shifting;
  assign tx_idle = !shifting && !pending;
  assign uart_tx = shift_q[0];

  assign tx_resp.rdata.raw = 32'h0;

  //////////////////////////////////////////////////
  // Serial shifter
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pending      <= 1'b0;
      shifting     <= 1'b0;
      thr_empty    <= 1'b1;
      tx_resp.done <= 1'b0;
      shift_q      <= '1;
      baud_cnt     <= '0;
      bit_cnt      <= '0;
    end else begin
      tx_resp.done <= load;
      if (load) begin
        pending <= 1'b0;
      end else if (tx_hit) begin
        pending <= 1'b1;
      end
      if (load) begin
        shifting  <= 1'b1;
        thr_empty <= 1'b0;
        // Stop, data LSB first, start
        shift_q   <= {1'b1, req.wdata[7:0], 1'b0};
        baud_cnt  <= '0;
        bit_cnt   <= '0;
      end else if (shifting) begin
        if (baud_cnt == bw'(`CLKS_PER_BIT - 1)) begin
          baud_cnt <= '0;
          shift_q  <= {1'b1, shift_q[9:1]};
          if (bit_cnt == 4'd9) begin
            shifting  <= 1'b0;
            thr_empty <= 1'b1;
          end else begin
            bit_cnt <= bit_cnt + 4'd1;
          end
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Line status register
  //////////////////////////////////////////////////

  always_comb begin
    lsr_now           = '0;
    lsr_now.rx_ready  = rx_full;
    lsr_now.thr_empty = thr_empty;
    lsr_now.tx_idle   = tx_idle;
  end

  always_ff @(posedge clk) begin
    if (lsr_hit) lsr_resp.rdata.lsr <= lsr_now;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      lsr_resp.done <= 1'b0;
    end else begin
      lsr_resp.done <= lsr_hit;
    end
  end

endmodule

// ==== uart_rx_port.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module uart_rx_port import soc_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic uart_rx,
  req_if.dst   req,
  resp_if.src  resp,
  output logic rx_full
);

  localparam int bw = $clog2(`CLKS_PER_BIT);

  logic          rx_meta;
  logic          rx_s;
  logic          receiving;
  logic [bw-1:0] cnt;
  logic [3:0]    bit_cnt;
  logic [7:0]    shift_q;
  logic [7:0]    hold_q;
  logic          tick;
  logic          stop_tick;
  logic          rd_hit;

  assign tick      = receiving && (cnt == '0);
  assign stop_tick = tick && (bit_cnt == 4'd9);
  assign rd_hit    = req.strobe && (req.sel == tgt_uart_rx);

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rx_meta <= 1'b1;
      rx_s    <= 1'b1;
    end else begin
      rx_meta <= uart_rx;
      rx_s    <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      receiving <= 1'b0;
      cnt       <= '0;
      bit_cnt   <= '0;
      rx_full   <= 1'b0;
      resp.done <= 1'b0;
    end else begin
      resp.done <= rd_hit;
      if (!receiving && !rx_s) begin
        // First sample lands half a bit in, mid start bit
        receiving <= 1'b1;
        cnt       <= bw'(`CLKS_PER_BIT / 2 - 1);
        bit_cnt   <= '0;
      end else if (tick) begin
        cnt     <= bw'(`CLKS_PER_BIT - 1);
        bit_cnt <= bit_cnt + 4'd1;
        // Start bit gone high again, treat as a glitch
        if ((bit_cnt == 4'd0) && rx_s) receiving <= 1'b0;
        if (bit_cnt == 4'd9) receiving <= 1'b0;
      end else if (receiving) begin
        cnt <= cnt - 1'b1;
      end
      if (stop_tick) begin
        rx_full <= 1'b1;
      end else if (rd_hit) begin
        rx_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tick && (bit_cnt != 4'd0) && (bit_cnt != 4'd9)) shift_q <= {rx_s, shift_q[7:1]};
    if (stop_tick) hold_q <= shift_q;
    if (rd_hit) resp.rdata.raw <= rx_full ? {24'h0, hold_q} : 32'hFFFF_FFFF;
  end

  a_stop_bit_high: assert property (
    @(posedge clk) disable iff (!resetn)
    stop_tick |-> rx_s
  );

endmodule

// ==== resp_mux.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module resp_mux import soc_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  resp_if.dst         bram,
  resp_if.dst         tx,
  resp_if.dst         rx,
  resp_if.dst         lsr,
  req_if.dst          req,
  input  logic        tx_idle,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  output logic        access_fault
);

  logic      freq_done;
  logic      unm_done;
  logic      any_done;
  bus_word_u word;

  assign any_done = bram.done | tx.done | rx.done | lsr.done | freq_done | unm_done;

  always_comb begin
    word.raw = 32'h0;
    if (bram.done)     word = bram.rdata;
    else if (tx.done)  word = tx.rdata;
    else if (rx.done)  word = rx.rdata;
    else if (lsr.done) word = lsr.rdata;
    else if (freq_done) word.raw = `SYS_CLK_HZ;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      freq_done    <= 1'b0;
      unm_done     <= 1'b0;
      mem_ready    <= 1'b0;
      access_fault <= 1'b0;
    end else begin
      freq_done    <= req.strobe && (req.sel == tgt_freq);
      unm_done     <= req.strobe && (req.sel == tgt_unmapped);
      mem_ready    <= any_done;
      access_fault <= unm_done;
    end
  end

  always_ff @(posedge clk) begin
    if (any_done) mem_rdata <= word.raw;
  end

  a_single_answer: assert property (
    @(posedge clk) disable iff (!resetn)
    $onehot0({bram.done, tx.done, rx.done, lsr.done, freq_done, unm_done})
  );

  // The byte just taken is already on its way out
  a_tx_busy_on_done: assert property (
    @(posedge clk) disable iff (!resetn)
    tx.done |-> !tx_idle
  );

endmodule

// ==== soc_bus.sv ====
`timescale 1ns/1ps

module soc_bus (
  input  logic        clk,
  input  logic        resetn,
  input  logic        mem_valid,
  input  logic [3:0]  mem_wstrb,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  input  logic        uart_rx,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  output logic        access_fault,
  output logic        uart_tx
);

  logic tx_idle;
  logic rx_full;

  req_if  req_bus ();
  resp_if bram_resp ();
  resp_if tx_resp ();
  resp_if lsr_resp ();
  resp_if rx_resp ();

  //////////////////////////////////////////////////
  // Decode, targets, response
  //////////////////////////////////////////////////

  addr_decode decode_i (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wstrb (mem_wstrb),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .req       (req_bus.src)
  );

  bram_store bram_i (
    .clk    (clk),
    .resetn (resetn),
    .req    (req_bus.dst),
    .resp   (bram_resp.src)
  );

  uart_tx_port uart_tx_i (
    .clk      (clk),
    .resetn   (resetn),
    .rx_full  (rx_full),
    .req      (req_bus.dst),
    .tx_resp  (tx_resp.src),
    .lsr_resp (lsr_resp.src),
    .uart_tx  (uart_tx),
    .tx_idle  (tx_idle)
  );

  uart_rx_port uart_rx_i (
    .clk     (clk),
    .resetn  (resetn),
    .uart_rx (uart_rx),
    .req     (req_bus.dst),
    .resp    (rx_resp.src),
    .rx_full (rx_full)
  );

  resp_mux resp_i (
    .clk          (clk),
    .resetn       (resetn),
    .bram         (bram_resp.dst),
    .tx           (tx_resp.dst),
    .rx           (rx_resp.dst),
    .lsr          (lsr_resp.dst),
    .req          (req_bus.dst),
    .tx_idle      (tx_idle),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata),
    .access_fault (access_fault)
  );

endmodule

// ==== tb_soc_bus.sv ====
`timescale 1ns/1ps
`include "soc_defines.svh"

module tb_soc_bus import soc_pkg::*; ();

  localparam int frame_cycles = 10 * `CLKS_PER_BIT;
  // Three UART frames, about a hundred bus accesses of 5 cycles each, plus margin
  localparam int max_cycles = 4000;

  logic        clk;
  logic        resetn;
  logic        mem_valid;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  logic        access_fault;
  logic        uart_tx;
  logic        uart_rx;

  int          errors = 0;
  int          cycle_count = 0;
  int          seed = 32'hb05247e4;
  logic [31:0] bram_model [`BRAM_WORDS];
  logic [31:0] last_addr;

  // Serial loopback, line held idle while in reset
  assign uart_rx = resetn ? uart_tx : 1'b1;

  soc_bus dut_i (
    .clk          (clk),
    .resetn       (resetn),
    .mem_valid    (mem_valid),
    .mem_wstrb    (mem_wstrb),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .uart_rx      (uart_rx),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata),
    .access_fault (access_fault),
    .uart_tx      (uart_tx)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input bus_word_u got, input bus_word_u exp);
    if (got.raw !== exp.raw) begin
      errors++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got.raw, exp.raw);
    end
  endtask

  task automatic check_lsr(input string name, input lsr_t got, input lsr_t exp);
    if (got.rx_ready !== exp.rx_ready) begin
      errors++;
      $display("[ERROR] %s.rx_ready got 0x%h expected 0x%h", name, got.rx_ready, exp.rx_ready);
    end
    if (got.thr_empty !== exp.thr_empty) begin
      errors++;
      $display("[ERROR] %s.thr_empty got 0x%h expected 0x%h", name, got.thr_empty,
               exp.thr_empty);
    end
    if (got.tx_idle !== exp.tx_idle) begin
      errors++;
      $display("[ERROR] %s.tx_idle got 0x%h expected 0x%h", name, got.tx_idle, exp.tx_idle);
    end
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_fault(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("%s answered %0d cycles after valid instead of %0d", what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Host bus
  //////////////////////////////////////////////////

  // Starts on a rising edge, returns one idle cycle after ready
  task automatic host_access(input logic [31:0] addr, input logic [3:0] wstrb,
                             input logic [31:0] wdata, output bus_word_u rdata,
                             output bit fault, output int lat);
    int n;
    n = 0;
    mem_valid <= 1'b1;
    mem_addr  <= addr;
    mem_wstrb <= wstrb;
    mem_wdata <= wdata;
    do begin
      @(posedge clk);
      n++;
    end while (!mem_ready);
    rdata.raw = mem_rdata;
    fault     = access_fault;
    // First edge only samples valid
    lat = n - 1;
    mem_valid <= 1'b0;
    mem_wstrb <= 4'h0;
    @(posedge clk);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] wstrb,
                           input logic [31:0] wdata, output bus_word_u rdata,
                           output bit fault, output int lat);
    host_access(addr, wstrb, wdata, rdata, fault, lat);
  endtask

  task automatic bus_read(input logic [31:0] addr, output bus_word_u rdata,
                          output bit fault, output int lat);
    host_access(addr, 4'h0, 32'h0, rdata, fault, lat);
  endtask

  // Poll line status until bit 8 shows a received byte
  task automatic wait_rx_ready();
    bus_word_u got;
    bit        fault;
    int        lat;
    bit        ok;
    ok = 1'b0;
    for (int i = 0; i < 100 && !ok; i++) begin
      bus_read(`UART_LSR_ADDR, got, fault, lat);
      ok = got.raw[8];
    end
    if (!ok) begin
      errors++;
      $display("Receiver never reported a byte within 100 line status polls");
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic reset_state_lsr();
    bus_word_u got;
    bus_word_u exp;
    bit        fault;
    int        lat;
    exp.raw     = 32'h0;
    exp.raw[13] = 1'b1;
    exp.raw[14] = 1'b1;
    bus_read(`UART_LSR_ADDR, got, fault, lat);
    check_lsr("lsr", got.lsr, exp.lsr);
    check_fault("access_fault", fault, 1'b0);
    check_latency("Line status read", lat, 3);
    bus_read(`UART_RX_ADDR, got, fault, lat);
    exp.raw = 32'hFFFF_FFFF;
    check_word("mem_rdata", got, exp);
    check_latency("Receive read", lat, 3);
  endtask

  task automatic bram_readback();
    logic [31:0] addrs [$];
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  strb;
    bus_word_u   got;
    bus_word_u   exp;
    bit          fault;
    int          lat;
    for (int i = 0; i < 12; i++) begin
      a = ($random(seed) & 32'hff) << 2;
      d = $random(seed);
      bus_write(a, 4'hf, d, got, fault, lat);
      check_fault("access_fault", fault, 1'b0);
      bram_model[a[9:2]] = d;
      addrs.push_back(a);
    end
    foreach (addrs[i]) begin
      a = addrs[i];
      bus_read(a, got, fault, lat);
      exp.raw = bram_model[a[9:2]];
      check_word("mem_rdata", got, exp);
      check_fault("access_fault", fault, 1'b0);
      check_latency("Block RAM read", lat, 3);
    end
    // Partial write merges only the strobed bytes
    a    = addrs[0];
    strb = $random(seed);
    if (strb == 4'h0 || strb == 4'hf) strb = 4'b0110;
    d = $random(seed);
    bus_write(a, strb, d, got, fault, lat);
    exp.raw = bram_model[a[9:2]];
    check_word("mem_rdata old word", got, exp);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) bram_model[a[9:2]][8*b +: 8] = d[8*b +: 8];
    end
    bus_read(a, got, fault, lat);
    exp.raw = bram_model[a[9:2]];
    check_word("mem_rdata", got, exp);
    check_latency("Block RAM read", lat, 3);
    last_addr = a;
  endtask

  task automatic freq_register();
    bus_word_u got;
    bus_word_u exp;
    bit        fault;
    int        lat;
    exp.raw = `SYS_CLK_HZ;
    bus_read(`FREQ_ADDR, got, fault, lat);
    check_word("mem_rdata", got, exp);
    check_fault("access_fault", fault, 1'b0);
    check_latency("Frequency read", lat, 3);
    bus_write(`FREQ_ADDR, 4'hf, $random(seed), got, fault, lat);
    check_fault("access_fault", fault, 1'b1);
    exp.raw = 32'h0;
    check_word("mem_rdata", got, exp);
    bus_read(`FREQ_ADDR, got, fault, lat);
    exp.raw = `SYS_CLK_HZ;
    check_word("mem_rdata", got, exp);
  endtask

  task automatic uart_loopback();
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] d2;
    int          t0;
    bus_word_u   got;
    bus_word_u   exp;
    bit          fault;
    int          lat;
    d0 = $random(seed);
    bus_write(`UART_TX_ADDR, 4'hf, d0, got, fault, lat);
    check_fault("access_fault", fault, 1'b0);
    check_latency("Transmit write on idle shifter", lat, 3);
    wait_rx_ready();
    bus_read(`UART_RX_ADDR, got, fault, lat);
    exp.raw = {24'h0, d0[7:0]};
    check_word("mem_rdata", got, exp);
    bus_read(`UART_RX_ADDR, got, fault, lat);
    exp.raw = 32'hFFFF_FFFF;
    check_word("mem_rdata", got, exp);

    // Second write lands while the first frame is on the line
    d1 = $random(seed);
    bus_write(`UART_TX_ADDR, 4'hf, d1, got, fault, lat);
    t0 = cycle_count;
    bus_read(`UART_LSR_ADDR, got, fault, lat);
    exp.raw = 32'h0;
    check_lsr("lsr", got.lsr, exp.lsr);
    d2 = $random(seed);
    bus_write(`UART_TX_ADDR, 4'hf, d2, got, fault, lat);
    if (cycle_count - t0 < frame_cycles - 4) begin
      errors++;
      $display("Second transmit write finished %0d cycles after the first, before its frame ended",
               cycle_count - t0);
    end
    wait_rx_ready();
    bus_read(`UART_RX_ADDR, got, fault, lat);
    exp.raw = {24'h0, d1[7:0]};
    check_word("mem_rdata", got, exp);
    wait_rx_ready();
    bus_read(`UART_RX_ADDR, got, fault, lat);
    exp.raw = {24'h0, d2[7:0]};
    check_word("mem_rdata", got, exp);
    bus_read(`UART_RX_ADDR, got, fault, lat);
    exp.raw = 32'hFFFF_FFFF;
    check_word("mem_rdata", got, exp);
  endtask

  task automatic unmapped_access();
    bus_word_u got;
    bus_word_u exp;
    bit        fault;
    int        lat;
    bus_read(32'h2000_0000, got, fault, lat);
    exp.raw = 32'h0;
    check_word("mem_rdata", got, exp);
    check_fault("access_fault", fault, 1'b1);
    check_latency("Unmapped read", lat, 3);
    bus_read(last_addr, got, fault, lat);
    exp.raw = bram_model[last_addr[9:2]];
    check_word("mem_rdata", got, exp);
    check_fault("access_fault", fault, 1'b0);
  endtask

  initial begin
    clk       = 1'b0;
    resetn    = 1'b0;
    mem_valid = 1'b0;
    mem_wstrb = 4'h0;
    mem_addr  = 32'h0;
    mem_wdata = 32'h0;
    repeat (5) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);

    reset_state_lsr();
    bram_readback();
    freq_register();
    uart_loopback();
    unmapped_access();

    $display("Run finished after %0d cycles with %0d errors", cycle_count, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+.
soc_pkg.sv
bus_if.sv
addr_decode.sv
bram_store.sv
uart_tx_port.sv
uart_rx_port.sv
resp_mux.sv
soc_bus.sv
tb_soc_bus.sv

// ==== Bender.yml ====
package:
  name: soc_bus

export_include_dirs:
  - .

sources:
  - soc_pkg.sv
  - bus_if.sv
  - addr_decode.sv
  - bram_store.sv
  - uart_tx_port.sv
  - uart_rx_port.sv
  - resp_mux.sv
  - soc_bus.sv
  - target: test
    files:
      - tb_soc_bus.sv
